//--- verilog/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Datapath widths.
`define XLEN  64
`define HXLEN 32

// ALU operation selects. Each equals the funct3 of the matching OP instruction.
`define ALU_CTRL_AOS  3'd0 // Add, or sub when alt is set.
`define ALU_CTRL_SLL  3'd1
`define ALU_CTRL_SLT  3'd2
`define ALU_CTRL_SLTU 3'd3 // Bit 0 set marks the unsigned compare.
`define ALU_CTRL_XOR  3'd4
`define ALU_CTRL_SR   3'd5 // Logical, or arithmetic when alt is set.
`define ALU_CTRL_OR   3'd6
`define ALU_CTRL_AND  3'd7

// Opcode classes seen by the execute stage.
`define OPC_W         3
`define OPC_OP        3'd0
`define OPC_OP_IMM    3'd1
`define OPC_OP_32     3'd2
`define OPC_OP_IMM_32 3'd3
`define OPC_BRANCH    3'd4

// Branch conditions in funct3.
`define F3_BEQ  3'b000
`define F3_BNE  3'b001
`define F3_BLT  3'b100
`define F3_BGE  3'b101
`define F3_BLTU 3'b110
`define F3_BGEU 3'b111

`endif

//--- verilog/rv_pkg.sv
`default_nettype none

`include "rv_defines.svh"

package rv_pkg;

	// Control word for the ALU, five bits wide.
	typedef struct packed {
		logic       w;   // 32-bit form.
		logic       alt; // Sub or arithmetic shift.
		logic [2:0] sel; // Operation select.
	} alu_ctrl_t;

	// One execute request as it arrives from decode.
	typedef struct packed {
		logic [`OPC_W-1:0] opc;
		logic [2:0]        funct3;
		logic              funct7_5; // Also imm bit 10 for immediate shifts.
		logic [`XLEN-1:0]  rs1;
		logic [`XLEN-1:0]  rs2;
		logic [`XLEN-1:0]  imm;
		logic [`XLEN-1:0]  pc;
	} ex_req_t;

	// Registered result of the stage.
	typedef struct packed {
		logic [`XLEN-1:0] result;
		logic             br_taken;
		logic [`XLEN-1:0] br_target;
		logic             illegal;
	} ex_resp_t;

endpackage

`default_nettype wire

//--- verilog/mux_key_default.sv
`timescale 1ns/1ps
`default_nettype none

module mux_key_default #(
	parameter int NR_KEY = 2,
	parameter int KEY_LEN = 1,
	parameter type data_t = logic [7:0],
	localparam int DATA_LEN = $bits(data_t),
	localparam int PAIR_LEN = KEY_LEN + DATA_LEN
) (
	input  wire logic                       clk,
	input  wire logic [KEY_LEN-1:0]         key,
	input  wire data_t                      default_out,
	input  wire logic [NR_KEY*PAIR_LEN-1:0] lut,
	output data_t                           out
);

	logic dup_key;

	// Each pair is {key, payload}, key in the upper bits.
	always_comb begin
		out = default_out;
		for (int i = 0; i < NR_KEY; i++) begin
			if (lut[i*PAIR_LEN+DATA_LEN +: KEY_LEN] == key) begin
				out = data_t'(lut[i*PAIR_LEN +: DATA_LEN]);
			end
		end
	end

	// Pairwise key compare over the whole table.
	always_comb begin
		dup_key = 1'b0;
		for (int i = 0; i < NR_KEY; i++) begin
			for (int j = i + 1; j < NR_KEY; j++) begin
				if (lut[i*PAIR_LEN+DATA_LEN +: KEY_LEN] == lut[j*PAIR_LEN+DATA_LEN +: KEY_LEN])
					dup_key = 1'b1;
			end
		end
	end

	a_unique_keys: assert property (@(posedge clk) !dup_key)
		else $error("mux_key_default has two equal keys in its table.");

endmodule

`default_nettype wire

//--- verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module alu (
	input  wire logic              clk,
	input  wire rv_pkg::alu_ctrl_t ctrl,
	input  wire logic [`XLEN-1:0]  a,
	input  wire logic [`XLEN-1:0]  b,
	output logic [`XLEN-1:0]       result,
	output logic                   smaller,
	output logic                   equal
);

	logic             sub;
	logic [`XLEN-1:0] b_op;
	logic [`XLEN:0]   add_full;
	logic [`XLEN-1:0] sum;
	logic             carry;
	logic             overflow;
	logic             smaller_s;
	logic             smaller_u;

	logic [`HXLEN-1:0] a_lo;
	logic [`HXLEN-1:0] sll_w, srl_w, sra_w;
	logic [`XLEN-1:0]  sll_out, sr_out;
	logic [`XLEN-1:0]  mux_out;

	// Compares always subtract.
	assign sub = ctrl.alt || (ctrl.sel == `ALU_CTRL_SLT) || (ctrl.sel == `ALU_CTRL_SLTU);
	assign b_op = sub ? ~b : b;
	assign add_full = {1'b0, a} + {1'b0, b_op} + {{`XLEN{1'b0}}, sub};
	assign sum = add_full[`XLEN-1:0];
	assign carry = add_full[`XLEN];

	assign overflow = (a[`XLEN-1] == b_op[`XLEN-1]) && (sum[`XLEN-1] != a[`XLEN-1]);
	assign smaller_s = sum[`XLEN-1] ^ overflow;
	assign smaller_u = ~carry; // No carry out means a borrow.
	assign smaller = ctrl.sel[0] ? smaller_u : smaller_s;
	assign equal = (sum == '0);

	// Low half shifts for the W forms.
	assign a_lo = a[`HXLEN-1:0];
	assign sll_w = a_lo << b[4:0];
	assign srl_w = a_lo >> b[4:0];
	assign sra_w = $signed(a_lo) >>> b[4:0];

	assign sll_out = ctrl.w ? {{`HXLEN{1'b0}}, sll_w} : (a << b[5:0]);

	always_comb begin
		if (ctrl.w)
			sr_out = {{`HXLEN{1'b0}}, ctrl.alt ? sra_w : srl_w};
		else if (ctrl.alt)
			sr_out = $signed(a) >>> b[5:0];
		else
			sr_out = a >> b[5:0];
	end

	mux_key_default #(
		.NR_KEY (8),
		.KEY_LEN(3),
		.data_t (logic [`XLEN-1:0])
	) u_alu_mux (
		.clk        (clk),
		.key        (ctrl.sel),
		.default_out('0),
		.lut({
			`ALU_CTRL_AOS,  sum,
			`ALU_CTRL_SLL,  sll_out,
			`ALU_CTRL_SLT,  {{(`XLEN-1){1'b0}}, smaller_s},
			`ALU_CTRL_SLTU, {{(`XLEN-1){1'b0}}, smaller_u},
			`ALU_CTRL_XOR,  a ^ b,
			`ALU_CTRL_SR,   sr_out,
			`ALU_CTRL_OR,   a | b,
			`ALU_CTRL_AND,  a & b
		}),
		.out        (mux_out)
	);

	// W results take bit 31 as sign.
	assign result = ctrl.w ? {{`HXLEN{mux_out[`HXLEN-1]}}, mux_out[`HXLEN-1:0]} : mux_out;

	a_ctrl_known: assert property (@(posedge clk) !$isunknown(ctrl))
		else $error("ALU control word is unknown.");

endmodule

`default_nettype wire

//--- verilog/alu_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module alu_decode (
	input  wire logic              clk,
	input  wire logic              in_valid,
	input  wire logic [`OPC_W-1:0] opc,
	input  wire logic [2:0]        funct3,
	input  wire logic              funct7_5,
	output rv_pkg::alu_ctrl_t      ctrl,
	output logic                   use_imm,
	output logic                   is_branch,
	output logic                   illegal
);

	localparam rv_pkg::alu_ctrl_t BR_SUB = '{w: 1'b0, alt: 1'b1, sel: `ALU_CTRL_AOS};
	localparam rv_pkg::alu_ctrl_t BR_SLT = '{w: 1'b0, alt: 1'b0, sel: `ALU_CTRL_SLT};
	localparam rv_pkg::alu_ctrl_t BR_SLTU = '{w: 1'b0, alt: 1'b0, sel: `ALU_CTRL_SLTU};

	rv_pkg::alu_ctrl_t br_ctrl;
	logic              w_ok; // Only add, sll and sr exist in W form.

	mux_key_default #(
		.NR_KEY (6),
		.KEY_LEN(3),
		.data_t (rv_pkg::alu_ctrl_t)
	) u_br_mux (
		.clk        (clk),
		.key        (funct3),
		.default_out(BR_SUB),
		.lut({
			`F3_BEQ,  BR_SUB,
			`F3_BNE,  BR_SUB,
			`F3_BLT,  BR_SLT,
			`F3_BGE,  BR_SLT,
			`F3_BLTU, BR_SLTU,
			`F3_BGEU, BR_SLTU
		}),
		.out        (br_ctrl)
	);

	assign w_ok = (funct3 == `ALU_CTRL_AOS) || (funct3 == `ALU_CTRL_SLL) ||
		(funct3 == `ALU_CTRL_SR);

	always_comb begin
		ctrl = '{w: 1'b0, alt: 1'b0, sel: funct3};
		use_imm = 1'b0;
		is_branch = 1'b0;
		illegal = 1'b0;
		case (opc)
			`OPC_OP: begin
				ctrl.alt = funct7_5;
				illegal = funct7_5 && (funct3 != `ALU_CTRL_AOS) && (funct3 != `ALU_CTRL_SR);
			end
			`OPC_OP_IMM: begin
				use_imm = 1'b1;
				ctrl.alt = funct7_5 && (funct3 == `ALU_CTRL_SR); // ADDI never subtracts.
				illegal = funct7_5 && (funct3 == `ALU_CTRL_SLL);
			end
			`OPC_OP_32: begin
				ctrl.w = 1'b1;
				ctrl.alt = funct7_5;
				illegal = !w_ok || (funct7_5 && (funct3 == `ALU_CTRL_SLL));
			end
			`OPC_OP_IMM_32: begin
				use_imm = 1'b1;
				ctrl.w = 1'b1;
				ctrl.alt = funct7_5 && (funct3 == `ALU_CTRL_SR);
				illegal = !w_ok || (funct7_5 && (funct3 == `ALU_CTRL_SLL));
			end
			`OPC_BRANCH: begin
				is_branch = 1'b1;
				ctrl = br_ctrl;
				illegal = (funct3 == 3'b010) || (funct3 == 3'b011);
			end
			default: illegal = 1'b1;
		endcase
	end

	a_branch_reg_only: assert property (@(posedge clk) in_valid |-> !(is_branch && use_imm))
		else $error("Branch decoded with immediate operand.");

endmodule

`default_nettype wire

//--- verilog/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module branch_unit (
	input  wire logic             is_branch,
	input  wire logic [2:0]       funct3,
	input  wire logic             smaller,
	input  wire logic             equal,
	input  wire logic [`XLEN-1:0] pc,
	input  wire logic [`XLEN-1:0] imm,
	output logic                  taken,
	output logic [`XLEN-1:0]      target
);

	logic cond;

	// Flags come from the ALU compare chosen by the decoder.
	always_comb begin
		case (funct3)
			`F3_BEQ:  cond = equal;
			`F3_BNE:  cond = !equal;
			`F3_BLT:  cond = smaller;  // Signed.
			`F3_BGE:  cond = !smaller;
			`F3_BLTU: cond = smaller;  // Unsigned.
			`F3_BGEU: cond = !smaller;
			default:  cond = 1'b0;
		endcase
	end

	assign taken = is_branch && cond;

	// Target is formed for every branch, taken or not.
	assign target = pc + imm;

endmodule

`default_nettype wire

//--- verilog/exec_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module exec_stage (
	input  wire logic            clk,
	input  wire logic            rst,
	input  wire logic            in_valid,
	input  wire rv_pkg::ex_req_t req,
	output logic                 out_valid,
	output rv_pkg::ex_resp_t     resp
);

	rv_pkg::alu_ctrl_t ctrl;
	logic              use_imm;
	logic              is_branch;
	logic              illegal;
	logic [`XLEN-1:0]  op_b;
	logic [`XLEN-1:0]  alu_result;
	logic              smaller;
	logic              equal;
	logic              br_taken;
	logic [`XLEN-1:0]  br_target;
	rv_pkg::ex_resp_t  resp_next;

	alu_decode u_decode (
		.clk      (clk),
		.in_valid (in_valid),
		.opc      (req.opc),
		.funct3   (req.funct3),
		.funct7_5 (req.funct7_5),
		.ctrl     (ctrl),
		.use_imm  (use_imm),
		.is_branch(is_branch),
		.illegal  (illegal)
	);

	assign op_b = use_imm ? req.imm : req.rs2; // Operand a is always rs1.

	alu u_alu (
		.clk    (clk),
		.ctrl   (ctrl),
		.a      (req.rs1),
		.b      (op_b),
		.result (alu_result),
		.smaller(smaller),
		.equal  (equal)
	);

	branch_unit u_branch (
		.is_branch(is_branch),
		.funct3   (req.funct3),
		.smaller  (smaller),
		.equal    (equal),
		.pc       (req.pc),
		.imm      (req.imm),
		.taken    (br_taken),
		.target   (br_target)
	);

	// Branches and illegal ops write no result.
	always_comb begin
		resp_next.result = (is_branch || illegal) ? '0 : alu_result;
		resp_next.br_taken = br_taken && !illegal;
		resp_next.br_target = is_branch ? br_target : '0;
		resp_next.illegal = illegal;
	end

	always_ff @(posedge clk) begin
		if (rst)
			out_valid <= 1'b0;
		else
			out_valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		if (in_valid)
			resp <= resp_next; // Holds while idle.
	end

	a_idle_after_rst: assert property (@(posedge clk) rst |=> !out_valid)
		else $error("out_valid high in the cycle after reset.");

endmodule

`default_nettype wire

//--- verif/exec_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module exec_stage_tb;

	localparam int MAX_VEC = 64;
	localparam int GAP_AFTER = 10; // Idle gap follows this many vectors.
	localparam int GAP_LEN = 3;
	localparam int XW = `XLEN;

	logic             clk;
	logic             rst;
	logic             in_valid;
	rv_pkg::ex_req_t  req;
	logic             out_valid;
	rv_pkg::ex_resp_t resp;

	rv_pkg::ex_req_t  vec_req [MAX_VEC];
	rv_pkg::ex_resp_t vec_exp [MAX_VEC];
	rv_pkg::ex_resp_t exp_q [$]; // Responses still owed by the DUT.
	rv_pkg::ex_resp_t last_resp;
	int               vec_count = 0;
	int               resp_count = 0;
	int               cycle_count = 0;
	int               cycle_limit = 0;

	exec_stage UUT (
		.clk      (clk),
		.rst      (rst),
		.in_valid (in_valid),
		.req      (req),
		.out_valid(out_valid),
		.resp     (resp)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// Run length is bounded by the number of vectors.
	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_limit > 0 && cycle_count > cycle_limit) begin
			$display("Timeout: the run went past %0d cycles.", cycle_limit);
			$display("Result: FAILED");
			$fatal(1, "Simulation timed out.");
		end
	end

	task automatic check_value(input string name, input logic [`XLEN-1:0] got,
		input logic [`XLEN-1:0] expected);
		if (got !== expected) begin
			$display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got,
				expected);
			$display("Result: FAILED");
			$fatal(1, "Mismatch on %s.", name);
		end
	endtask

	task automatic read_vectors();
		int          fd;
		int          n;
		string       line;
		logic [63:0] f [11];
		fd = $fopen("verif/exec_vectors.txt", "r");
		if (fd == 0) begin
			$display("Could not open the vector file verif/exec_vectors.txt.");
			$display("Result: FAILED");
			$fatal(1, "No vectors.");
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n > 1 && line.getc(0) != "#") begin
				n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
					f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
				if (n != 11 || vec_count >= MAX_VEC) begin
					$display("Bad or surplus vector line: %s", line);
					$display("Result: FAILED");
					$fatal(1, "Vector file unreadable.");
				end
				vec_req[vec_count] = '{opc: f[0][`OPC_W-1:0], funct3: f[1][2:0],
					funct7_5: f[2][0], rs1: f[3], rs2: f[4], imm: f[5], pc: f[6]};
				vec_exp[vec_count] = '{result: f[7], br_taken: f[8][0], br_target: f[9],
					illegal: f[10][0]};
				vec_count++;
			end
		end
		$fclose(fd);
	endtask

	task automatic drive_vector(input int idx);
		in_valid = 1'b1;
		req = vec_req[idx];
		exp_q.push_back(vec_exp[idx]);
	endtask

	// Wait for the next edge and check what the stage registered there.
	task automatic next_cycle();
		logic             exp_valid;
		rv_pkg::ex_resp_t exp_resp;
		exp_valid = in_valid;
		@(posedge clk);
		#1;
		check_value("out_valid", XW'(out_valid), XW'(exp_valid));
		if (exp_valid) begin
			if (exp_q.size() == 0) begin
				$display("A response was due but no expected value was queued.");
				$display("Result: FAILED");
				$fatal(1, "Expected queue empty.");
			end
			exp_resp = exp_q.pop_front();
			check_value("resp.result", resp.result, exp_resp.result);
			check_value("resp.br_taken", XW'(resp.br_taken), XW'(exp_resp.br_taken));
			check_value("resp.br_target", resp.br_target, exp_resp.br_target);
			check_value("resp.illegal", XW'(resp.illegal), XW'(exp_resp.illegal));
			last_resp = exp_resp;
			resp_count++;
		end else if (resp_count > 0) begin
			// Idle cycles keep the last response.
			check_value("resp.result", resp.result, last_resp.result);
			check_value("resp.br_taken", XW'(resp.br_taken), XW'(last_resp.br_taken));
			check_value("resp.br_target", resp.br_target, last_resp.br_target);
			check_value("resp.illegal", XW'(resp.illegal), XW'(last_resp.illegal));
		end
	endtask

	initial begin
		rst = 1'b1;
		in_valid = 1'b0;
		req = '0;
		read_vectors();
		cycle_limit = vec_count + 20;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		repeat (2) next_cycle(); // Stage stays idle with no stimulus.
		for (int i = 0; i < vec_count; i++) begin
			drive_vector(i);
			next_cycle();
			if (i == GAP_AFTER - 1) begin
				in_valid = 1'b0;
				repeat (GAP_LEN) next_cycle();
			end
		end
		in_valid = 1'b0;
		next_cycle();
		next_cycle();
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/exec_vectors.txt
# opc funct3 funct7_5 rs1 rs2 imm pc | result br_taken br_target illegal, all hex
# opc: 0 OP, 1 OP_IMM, 2 OP_32, 3 OP_IMM_32, 4 BRANCH
0 0 0 5 7 0 0 c 0 0 0
0 0 0 7fffffffffffffff 1 0 0 8000000000000000 0 0 0
0 0 1 3 5 0 0 fffffffffffffffe 0 0 0
0 0 1 8000000000000000 1 0 0 7fffffffffffffff 0 0 0
0 7 0 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 0 0 f000f000f000f000 0 0 0
0 6 0 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 0 0 fff0fff0fff0fff0 0 0 0
0 4 0 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 0 0 0ff00ff00ff00ff0 0 0 0
1 0 0 10 123 ffffffffffffffe0 0 fffffffffffffff0 0 0 0
1 0 1 1 0 400 0 401 0 0 0
0 2 0 ffffffffffffffff 1 0 0 1 0 0 0
0 3 0 ffffffffffffffff 1 0 0 0 0 0 0
0 1 0 1 3f 0 0 8000000000000000 0 0 0
0 5 0 8000000000000000 3c 0 0 8 0 0 0
0 5 1 8000000000000000 3c 0 0 fffffffffffffff8 0 0 0
1 5 1 f000000000000000 0 404 0 ff00000000000000 0 0 0
2 0 0 7fffffff 1 0 0 ffffffff80000000 0 0 0
2 1 0 1 3f 0 0 ffffffff80000000 0 0 0
2 5 0 ffffffff80000000 21 0 0 40000000 0 0 0
2 5 1 80000000 4 0 0 fffffffff8000000 0 0 0
3 0 0 fffffffe 0 3 0 1 0 0 0
3 5 1 f0000000 0 408 0 fffffffffff00000 0 0 0
4 0 0 5 5 10 80000000 0 1 80000010 0
4 0 0 5 6 10 80000000 0 0 80000010 0
4 1 0 5 6 fffffffffffffff8 80000100 0 1 800000f8 0
4 1 0 5 5 fffffffffffffff8 80000100 0 0 800000f8 0
4 4 0 ffffffffffffffff 1 10 80000000 0 1 80000010 0
4 4 0 1 ffffffffffffffff 10 80000000 0 0 80000010 0
4 5 0 1 ffffffffffffffff 10 80000000 0 1 80000010 0
4 5 0 ffffffffffffffff 1 10 80000000 0 0 80000010 0
4 5 0 7 7 20 1000 0 1 1020 0
4 6 0 1 ffffffffffffffff 10 80000000 0 1 80000010 0
4 6 0 ffffffffffffffff 1 10 80000000 0 0 80000010 0
4 7 0 ffffffffffffffff 1 10 80000000 0 1 80000010 0
4 7 0 1 ffffffffffffffff 10 80000000 0 0 80000010 0
0 1 1 5 1 0 0 0 0 0 1
2 2 0 1 2 0 0 0 0 0 1

//--- build.f
+incdir+verilog
verilog/rv_pkg.sv
verilog/mux_key_default.sv
verilog/alu.sv
verilog/alu_decode.sv
verilog/branch_unit.sv
verilog/exec_stage.sv
verif/exec_stage_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= exec_stage_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

# Build and run; the log decides pass or fail.
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
